// File: hw/gpreg_mon_pkg.sv
`default_nettype none

package gpreg_mon_pkg;

  // ********************************************************************
  // bus geometry
  // ********************************************************************

  // request/ack bus widths
  parameter int up_addr_width = 14;
  parameter int up_data_width = 32;

  // register offsets inside one slice, address bits 3 to 0
  typedef enum logic [3:0] {
    REG_D_RESETN = 4'h0,
    REG_D_COUNT  = 4'h2
  } reg_offset_e;

  // ********************************************************************
  // state encodings
  // ********************************************************************

  // count hand-off from d_clk to up_clk
  typedef enum logic [1:0] {
    XFER_IDLE = 2'd0,
    XFER_REQ  = 2'd1,
    XFER_WAIT = 2'd2
  } xfer_state_e;

  // per-direction tracker in the merge block
  typedef enum logic [1:0] {
    MERGE_IDLE    = 2'd0,
    MERGE_WAIT    = 2'd1,
    MERGE_TIMEOUT = 2'd2
  } merge_state_e;

  // read data for an address nobody owns
  parameter logic [up_data_width-1:0] bus_err_data = 32'hdead_beef;

endpackage

`default_nettype wire

// File: hw/up_clock_mon.sv
`timescale 1ns/1ps
`default_nettype none

module up_clock_mon
  import gpreg_mon_pkg::*;
#(
  parameter int window_log2 = 16
) (
  input  logic                     up_rstn,
  input  logic                     up_clk,
  input  logic                     d_clk,
  input  logic                     d_enable,
  output logic [up_data_width-1:0] up_d_count
);

  // up_clk side
  logic [window_log2-1:0]   up_win_count;
  xfer_state_e              up_xfer_state;
  logic                     up_req_toggle;
  logic [2:0]               up_ack_m;

  // d_clk side
  logic [2:0]               d_rst_m;
  logic                     d_rstn;
  logic [2:0]               d_req_m;
  logic                     d_req_edge;
  logic [up_data_width-1:0] d_count;
  logic [up_data_width-1:0] d_count_hold;

  // ********************************************************************
  // up_clk domain
  // ********************************************************************

  // ack toggle comes back from d_clk
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_ack_m <= '0;
    end else begin
      up_ack_m <= {up_ack_m[1:0], d_req_m[2]};
    end
  end

  // window timer, one request per wrap
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_win_count  <= '0;
      up_xfer_state <= XFER_IDLE;
      up_req_toggle <= 1'b0;
      up_d_count    <= '0;
    end else begin
      up_win_count <= up_win_count + 1'b1;
      case (up_xfer_state)
        XFER_IDLE: begin
          // last cycle of the window
          if (up_win_count == '1) begin
            up_xfer_state <= XFER_REQ;
          end
        end
        XFER_REQ: begin
          up_req_toggle <= ~up_req_toggle;
          up_xfer_state <= XFER_WAIT;
        end
        XFER_WAIT: begin
          // hold register is stable once the toggle is back
          if (up_ack_m[2] == up_req_toggle) begin
            up_d_count    <= d_count_hold;
            up_xfer_state <= XFER_IDLE;
          end
        end
        default: begin
          up_xfer_state <= XFER_IDLE;
        end
      endcase
    end
  end

  // ********************************************************************
  // d_clk domain
  // ********************************************************************

  // enable into d_clk, low keeps the counter in reset
  always_ff @(posedge d_clk) begin
    d_rst_m <= {d_rst_m[1:0], d_enable};
  end

  assign d_rstn = d_rst_m[2];

  // request toggle into d_clk, runs even while disabled
  always_ff @(posedge d_clk) begin
    d_req_m <= {d_req_m[1:0], up_req_toggle};
  end

  assign d_req_edge = d_req_m[2] ^ d_req_m[1];

  // cycle counter, restarts at each latch
  always_ff @(posedge d_clk) begin
    if (!d_rstn) begin
      d_count      <= '0;
      d_count_hold <= '0;
    end else begin
      if (d_req_edge) begin
        d_count_hold <= d_count;
        d_count      <= 32'd1;
      end else if (d_count != '1) begin
        // saturate, never wrap
        d_count <= d_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_gpreg_clock_mon.sv
`timescale 1ns/1ps
`default_nettype none

module axi_gpreg_clock_mon
  import gpreg_mon_pkg::*;
#(
  parameter int unsigned id          = 0,
  parameter int          window_log2 = 16
) (
  input  logic                     up_rstn,
  input  logic                     up_clk,
  input  logic                     d_clk,
  input  logic                     up_wreq,
  input  logic [up_addr_width-1:0] up_waddr,
  input  logic [up_data_width-1:0] up_wdata,
  output logic                     up_wack,
  input  logic                     up_rreq,
  input  logic [up_addr_width-1:0] up_raddr,
  output logic [up_data_width-1:0] up_rdata,
  output logic                     up_rack
);

  // block select lives in address bits 13 to 4
  localparam logic [up_addr_width-5:0] block_sel = id[up_addr_width-5:0];

  logic                     up_wreq_s;
  logic                     up_rreq_s;
  logic                     up_d_resetn;
  logic [up_data_width-1:0] up_d_count_s;

  // requests aimed at this slice only
  assign up_wreq_s = up_wreq & (up_waddr[up_addr_width-1:4] == block_sel);
  assign up_rreq_s = up_rreq & (up_raddr[up_addr_width-1:4] == block_sel);

  // ********************************************************************
  // write side
  // ********************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack     <= 1'b0;
      up_d_resetn <= 1'b0;
    end else begin
      // one cycle ack
      up_wack <= up_wreq_s;
      if (up_wreq_s && (up_waddr[3:0] == REG_D_RESETN)) begin
        up_d_resetn <= up_wdata[0];
      end
    end
  end

  // ********************************************************************
  // read side
  // ********************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= up_rreq_s;
      if (up_rreq_s) begin
        case (reg_offset_e'(up_raddr[3:0]))
          REG_D_RESETN: up_rdata <= {{(up_data_width-1){1'b0}}, up_d_resetn};
          REG_D_COUNT:  up_rdata <= up_d_count_s;
          default:      up_rdata <= '0;
        endcase
      end else begin
        // zero keeps the merge OR clean
        up_rdata <= '0;
      end
    end
  end

  // measured clock, held in reset until enabled
  up_clock_mon #(
    .window_log2 (window_log2)
  ) clock_mon_i (
    .up_rstn    (up_rstn),
    .up_clk     (up_clk),
    .d_clk      (d_clk),
    .d_enable   (up_d_resetn),
    .up_d_count (up_d_count_s)
  );

endmodule

`default_nettype wire

// File: hw/up_bus_merge.sv
`timescale 1ns/1ps
`default_nettype none

module up_bus_merge
  import gpreg_mon_pkg::*;
#(
  parameter int timeout_cycles = 16
) (
  input  logic                     up_rstn,
  input  logic                     up_clk,
  input  logic                     up_wreq,
  input  logic                     up_rreq,
  input  logic                     s0_wack,
  input  logic                     s0_rack,
  input  logic [up_data_width-1:0] s0_rdata,
  input  logic                     s1_wack,
  input  logic                     s1_rack,
  input  logic [up_data_width-1:0] s1_rdata,
  output logic                     up_wack,
  output logic                     up_rack,
  output logic [up_data_width-1:0] up_rdata
);

  localparam int cnt_w = (timeout_cycles > 2) ? $clog2(timeout_cycles) : 1;

  // index 0 is write, index 1 is read
  wire [1:0] trk_req;
  wire [1:0] trk_sack;
  wire [1:0] trk_fwd;
  wire [1:0] trk_tmo;

  assign trk_req  = {up_rreq, up_wreq};
  assign trk_sack = {s0_rack | s1_rack, s0_wack | s1_wack};

  // ********************************************************************
  // request trackers
  // ********************************************************************

  for (genvar ch = 0; ch < 2; ch++) begin : g_trk
    merge_state_e     state;
    logic [cnt_w-1:0] count;

    // slice ack while waiting, or timeout reached
    assign trk_fwd[ch] = (state == MERGE_WAIT) & trk_sack[ch];
    assign trk_tmo[ch] = (state == MERGE_TIMEOUT);

    always_ff @(posedge up_clk) begin
      if (!up_rstn) begin
        state <= MERGE_IDLE;
        count <= '0;
      end else begin
        case (state)
          MERGE_IDLE: begin
            // acks seen here are stale, dropped
            count <= '0;
            if (trk_req[ch]) begin
              state <= MERGE_WAIT;
            end
          end
          MERGE_WAIT: begin
            count <= count + 1'b1;
            if (trk_sack[ch]) begin
              state <= MERGE_IDLE;
            end else if (count == cnt_w'(timeout_cycles - 2)) begin
              state <= MERGE_TIMEOUT;
            end
          end
          MERGE_TIMEOUT: begin
            state <= MERGE_IDLE;
          end
          default: begin
            state <= MERGE_IDLE;
          end
        endcase
      end
    end
  end

  // ********************************************************************
  // registered response
  // ********************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack <= trk_fwd[0] | trk_tmo[0];
      up_rack <= trk_fwd[1] | trk_tmo[1];
      // slices drive zero when idle, OR is safe
      if (trk_fwd[1]) begin
        up_rdata <= s0_rdata | s1_rdata;
      end else if (trk_tmo[1]) begin
        up_rdata <= bus_err_data;
      end else begin
        up_rdata <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/axi_gpreg_mon.sv
`timescale 1ns/1ps
`default_nettype none

module axi_gpreg_mon
  import gpreg_mon_pkg::*;
#(
  parameter int          window_log2    = 16,
  parameter int unsigned mon0_id        = 1,
  parameter int unsigned mon1_id        = 2,
  parameter int          timeout_cycles = 16
) (
  input  logic                     up_rstn,
  input  logic                     up_clk,
  input  logic                     d_clk0,
  input  logic                     d_clk1,
  input  logic                     up_wreq,
  input  logic [up_addr_width-1:0] up_waddr,
  input  logic [up_data_width-1:0] up_wdata,
  output logic                     up_wack,
  input  logic                     up_rreq,
  input  logic [up_addr_width-1:0] up_raddr,
  output logic [up_data_width-1:0] up_rdata,
  output logic                     up_rack
);

  // per-slice responses into the merge
  logic                     mon0_wack;
  logic                     mon0_rack;
  logic [up_data_width-1:0] mon0_rdata;
  logic                     mon1_wack;
  logic                     mon1_rack;
  logic [up_data_width-1:0] mon1_rdata;

  // ********************************************************************
  // monitor slices, shared request bus
  // ********************************************************************

  // slice on d_clk0
  axi_gpreg_clock_mon #(
    .id          (mon0_id),
    .window_log2 (window_log2)
  ) mon0_i (
    .up_rstn  (up_rstn),
    .up_clk   (up_clk),
    .d_clk    (d_clk0),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (mon0_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (mon0_rdata),
    .up_rack  (mon0_rack)
  );

  // slice on d_clk1
  axi_gpreg_clock_mon #(
    .id          (mon1_id),
    .window_log2 (window_log2)
  ) mon1_i (
    .up_rstn  (up_rstn),
    .up_clk   (up_clk),
    .d_clk    (d_clk1),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (mon1_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (mon1_rdata),
    .up_rack  (mon1_rack)
  );

  // one response, timeout for unclaimed addresses
  up_bus_merge #(
    .timeout_cycles (timeout_cycles)
  ) merge_i (
    .up_rstn  (up_rstn),
    .up_clk   (up_clk),
    .up_wreq  (up_wreq),
    .up_rreq  (up_rreq),
    .s0_wack  (mon0_wack),
    .s0_rack  (mon0_rack),
    .s0_rdata (mon0_rdata),
    .s1_wack  (mon1_wack),
    .s1_rack  (mon1_rack),
    .s1_rdata (mon1_rdata),
    .up_wack  (up_wack),
    .up_rack  (up_rack),
    .up_rdata (up_rdata)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real up_period    = 8.0,
  parameter real d0_period    = 10.0,
  parameter real d1_period    = 6.0,
  parameter int  reset_cycles = 8
) (
  output logic up_clk,
  output logic d_clk0,
  output logic d_clk1,
  output logic up_rstn
);

  // bus clock
  initial begin
    up_clk = 1'b0;
    forever #(up_period / 2.0) up_clk = ~up_clk;
  end

  // measured clocks, free running
  initial begin
    d_clk0 = 1'b0;
    forever #(d0_period / 2.0) d_clk0 = ~d_clk0;
  end

  initial begin
    d_clk1 = 1'b0;
    forever #(d1_period / 2.0) d_clk1 = ~d_clk1;
  end

  // low for reset_cycles edges, released on a falling edge
  initial begin
    up_rstn = 1'b0;
    repeat (reset_cycles) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/axi_gpreg_mon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_gpreg_mon_tb
  import gpreg_mon_pkg::*;
();

  // ********************************************************************
  // test setup
  // ********************************************************************

  localparam int win_log2     = 8;
  localparam int win_cycles   = 1 << win_log2;
  localparam int tmo_cycles   = 16;
  localparam int mon0_sel     = 1;
  localparam int mon1_sel     = 2;
  localparam int up_period_ps = 8000;
  localparam int d0_period_ps = 10000;
  localparam int d1_period_ps = 6000;
  // slice register, then merge register
  localparam int claimed_lat   = 2;
  localparam int unclaimed_lat = tmo_cycles + 1;
  localparam int ack_limit     = 4 * tmo_cycles;
  // d_clk cycles per window, rounded
  localparam int exp_cnt0 = (win_cycles * up_period_ps + d0_period_ps / 2) / d0_period_ps;
  localparam int exp_cnt1 = (win_cycles * up_period_ps + d1_period_ps / 2) / d1_period_ps;
  localparam int cnt_tol  = 2;
  // six tests of up to four windows each is ~6k cycles
  localparam int max_cycles = 20000;

  logic        up_clk;
  logic        d_clk0;
  logic        d_clk1;
  logic        up_rstn;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_wack;
  logic        up_rreq;
  logic [13:0] up_raddr;
  logic [31:0] up_rdata;
  logic        up_rack;

  int          cycle_count = 0;
  int          check_bad;
  int          bad_at_start;
  int          test_ok;
  int          test_bad;
  logic [31:0] rnd_data;
  logic [9:0]  unmapped_sel;

  tb_clk_gen #(
    .up_period    (up_period_ps / 1000.0),
    .d0_period    (d0_period_ps / 1000.0),
    .d1_period    (d1_period_ps / 1000.0),
    .reset_cycles (8)
  ) clk_gen_i (
    .up_clk  (up_clk),
    .d_clk0  (d_clk0),
    .d_clk1  (d_clk1),
    .up_rstn (up_rstn)
  );

  axi_gpreg_mon #(
    .window_log2    (win_log2),
    .mon0_id        (mon0_sel),
    .mon1_id        (mon1_sel),
    .timeout_cycles (tmo_cycles)
  ) dut_i (
    .up_rstn  (up_rstn),
    .up_clk   (up_clk),
    .d_clk0   (d_clk0),
    .d_clk1   (d_clk1),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack)
  );

  // ********************************************************************
  // helpers
  // ********************************************************************

  // block select in bits 13 to 4
  function automatic logic [13:0] make_addr(input int sel, input logic [3:0] off);
    return {sel[9:0], off};
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      check_bad++;
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi,
                             input logic [31:0] actual);
    assert ((actual >= lo) && (actual <= hi)) else begin
      $display("FAILED %s: expected 0x%0h to 0x%0h, got 0x%0h", name, lo, hi, actual);
      check_bad++;
    end
  endtask

  // one-cycle request, then wait for the ack pulse
  task automatic bus_write(input logic [13:0] addr, input logic [31:0] data,
                           output int latency);
    int n;
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    n        = 0;
    latency  = -1;
    while ((latency < 0) && (n < ack_limit)) begin
      @(negedge up_clk);
      up_wreq = 1'b0;
      n++;
      if (up_wack) begin
        latency = n;
      end
    end
    assert (latency >= 0) else begin
      $display("no write ack for address 0x%04h within %0d cycles", addr, ack_limit);
      check_bad++;
    end
  endtask

  // rdata only valid in the ack cycle
  task automatic bus_read(input logic [13:0] addr, output logic [31:0] data,
                          output int latency);
    int n;
    @(negedge up_clk);
    up_rreq  = 1'b1;
    up_raddr = addr;
    n        = 0;
    latency  = -1;
    data     = '0;
    while ((latency < 0) && (n < ack_limit)) begin
      @(negedge up_clk);
      up_rreq = 1'b0;
      n++;
      if (up_rack) begin
        latency = n;
        data    = up_rdata;
      end
    end
    assert (latency >= 0) else begin
      $display("no read ack for address 0x%04h within %0d cycles", addr, ack_limit);
      check_bad++;
    end
  endtask

  task automatic write_expect(input logic [13:0] addr, input logic [31:0] data,
                              input int exp_lat, input string name);
    int lat;
    bus_write(addr, data, lat);
    if (lat >= 0) begin
      check_equal({name, " up_wack latency"}, exp_lat, lat);
    end
  endtask

  task automatic read_expect(input logic [13:0] addr, input logic [31:0] exp_data,
                             input int exp_lat, input string name);
    logic [31:0] data;
    int          lat;
    bus_read(addr, data, lat);
    if (lat >= 0) begin
      check_equal({name, " up_rack latency"}, exp_lat, lat);
      check_equal({name, " up_rdata"}, exp_data, data);
    end
  endtask

  // count register within tolerance
  task automatic read_near(input logic [13:0] addr, input int exp_cnt, input string name);
    logic [31:0] data;
    int          lat;
    bus_read(addr, data, lat);
    if (lat >= 0) begin
      check_equal({name, " up_rack latency"}, claimed_lat, lat);
      check_range({name, " up_rdata"}, exp_cnt - cnt_tol, exp_cnt + cnt_tol, data);
    end
  endtask

  // no requests issued, so no acks either
  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge up_clk);
      check_equal("up_wack", 1'b0, up_wack);
      check_equal("up_rack", 1'b0, up_rack);
      check_equal("up_rdata", 32'h0, up_rdata);
    end
  endtask

  // extra cycles cover the count hand-off
  task automatic wait_windows(input int n);
    repeat (n * win_cycles + 16) @(negedge up_clk);
  endtask

  task automatic open_test();
    bad_at_start = check_bad;
  endtask

  task automatic close_test(input int num, input string title);
    if (check_bad == bad_at_start) begin
      test_ok++;
      $display("test %0d %s: ok", num, title);
    end else begin
      test_bad++;
      $display("test %0d %s: failed", num, title);
    end
  endtask

  // ********************************************************************
  // run limit
  // ********************************************************************

  always @(posedge up_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("run stopped, cycle limit of %0d reached", max_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // ********************************************************************
  // tests
  // ********************************************************************

  initial begin
    rnd_data     = $urandom(32'h277d6204);
    up_wreq      = 1'b0;
    up_waddr     = '0;
    up_wdata     = '0;
    up_rreq      = 1'b0;
    up_raddr     = '0;
    check_bad    = 0;
    bad_at_start = 0;
    test_ok      = 0;
    test_bad     = 0;
    unmapped_sel = '0;
    wait (up_rstn === 1'b1);
    @(negedge up_clk);

    open_test();
    idle_check(8);
    read_expect(make_addr(mon0_sel, REG_D_RESETN), 32'h0, claimed_lat, "mon0 d_resetn");
    read_expect(make_addr(mon0_sel, REG_D_COUNT), 32'h0, claimed_lat, "mon0 count");
    read_expect(make_addr(mon1_sel, REG_D_RESETN), 32'h0, claimed_lat, "mon1 d_resetn");
    read_expect(make_addr(mon1_sel, REG_D_COUNT), 32'h0, claimed_lat, "mon1 count");
    close_test(1, "after reset");

    open_test();
    write_expect(make_addr(mon0_sel, REG_D_RESETN), 32'h1, claimed_lat, "mon0 d_resetn");
    read_expect(make_addr(mon0_sel, REG_D_RESETN), 32'h1, claimed_lat, "mon0 d_resetn");
    read_expect(make_addr(mon1_sel, REG_D_RESETN), 32'h0, claimed_lat, "mon1 d_resetn");
    read_expect(make_addr(mon0_sel, 4'h5), 32'h0, claimed_lat, "mon0 offset 5");
    close_test(2, "reset control write and readback");

    open_test();
    wait_windows(3);
    read_near(make_addr(mon0_sel, REG_D_COUNT), exp_cnt0, "mon0 count");
    read_expect(make_addr(mon1_sel, REG_D_COUNT), 32'h0, claimed_lat, "mon1 count");
    close_test(3, "slice 0 count");

    open_test();
    write_expect(make_addr(mon1_sel, REG_D_RESETN), 32'h1, claimed_lat, "mon1 d_resetn");
    wait_windows(3);
    read_near(make_addr(mon1_sel, REG_D_COUNT), exp_cnt1, "mon1 count");
    read_near(make_addr(mon0_sel, REG_D_COUNT), exp_cnt0, "mon0 count");
    close_test(4, "slice 1 count");

    open_test();
    // any block select that no slice owns
    while ((unmapped_sel == mon0_sel) || (unmapped_sel == mon1_sel) || (unmapped_sel == 0)) begin
      rnd_data     = $urandom;
      unmapped_sel = rnd_data[13:4];
    end
    rnd_data = $urandom;
    read_expect(make_addr(unmapped_sel, rnd_data[3:0]), 32'hdead_beef, unclaimed_lat,
                "unclaimed read");
    // bit 0 clear, would disable a slice if it landed
    rnd_data = $urandom & 32'hffff_fffe;
    write_expect(make_addr(unmapped_sel, REG_D_RESETN), rnd_data, unclaimed_lat,
                 "unclaimed write");
    read_expect(make_addr(mon0_sel, REG_D_RESETN), 32'h1, claimed_lat, "mon0 d_resetn");
    read_expect(make_addr(mon1_sel, REG_D_RESETN), 32'h1, claimed_lat, "mon1 d_resetn");
    close_test(5, "unclaimed address");

    open_test();
    write_expect(make_addr(mon0_sel, REG_D_RESETN), 32'h0, claimed_lat, "mon0 d_resetn");
    wait_windows(3);
    read_expect(make_addr(mon0_sel, REG_D_COUNT), 32'h0, claimed_lat, "mon0 count");
    read_near(make_addr(mon1_sel, REG_D_COUNT), exp_cnt1, "mon1 count");
    close_test(6, "disable clears count");

    $display("tests: %0d ok, %0d failed; failed checks: %0d", test_ok, test_bad, check_bad);
    if ((check_bad == 0) && (test_bad == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gpreg_mon.f
hw/gpreg_mon_pkg.sv
hw/up_clock_mon.sv
hw/axi_gpreg_clock_mon.sv
hw/up_bus_merge.sv
hw/axi_gpreg_mon.sv
test/tb_clk_gen.sv
test/axi_gpreg_mon_tb.sv
